/* verilog/tuner_params.svh */
`ifndef TUNER_PARAMS_SVH
`define TUNER_PARAMS_SVH

// --------------------
// Datapath widths
// --------------------
`define TUNER_DAC_WIDTH 8
`define TUNER_ADC_WIDTH 8
`define TUNER_STRIDE_WIDTH 3

// Peak slots kept per search
`define TUNER_NUM_TARGET 8

// --------------------
// Peak detection
// --------------------
// Samples on each side of the candidate
`define TUNER_PEAK_HALF_WIN 4
// Min rise or fall votes in a half window
`define TUNER_PEAK_THRES 2
// Candidates skipped after a committed peak, four times the threshold
`define TUNER_PEAK_HOLDOFF (4 * `TUNER_PEAK_THRES)

`endif

/* verilog/tuner_types_pkg.sv */
`default_nettype none

`include "tuner_params.svh"

package tuner_types_pkg;

  // DAC tune code and measured optical power
  typedef logic [`TUNER_DAC_WIDTH-1:0] tune_code_t;
  typedef logic [`TUNER_ADC_WIDTH-1:0] pwr_t;

  // Sweep step is 2**stride
  typedef logic [`TUNER_STRIDE_WIDTH-1:0] tune_stride_t;

  // Peak count runs 0..NUM_TARGET, so one extra bit over the index
  typedef logic [$clog2(`TUNER_NUM_TARGET+1)-1:0] peak_cnt_t;
  typedef logic [$clog2(`TUNER_NUM_TARGET)-1:0] peak_idx_t;

endpackage

`default_nettype wire

/* verilog/search_state_pkg.sv */
`default_nettype none

package search_state_pkg;

  // Top level search FSM
  // S_INIT lasts one cycle and clears the datapath
  typedef enum logic [1:0] {
    S_IDLE,
    S_INIT,
    S_ACTIVE,
    S_DONE
  } search_state_e;

endpackage

`default_nettype wire

/* verilog/tuner_sample_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface tuner_sample_if;
  import tuner_types_pkg::*;

  // One cycle pulse while the search initializes
  logic       refresh;
  // Pulse per accepted measurement
  logic       update;
  // Code and power of that measurement, valid with update
  tune_code_t code;
  pwr_t       power;

  // Sequencer publishes samples
  modport seq(output refresh, output update, output code, output power);

  // Detector consumes the whole sample stream
  modport det(input refresh, input update, input code, input power);

  // Recorder only needs the clear pulse
  modport rec(input refresh);

endinterface

`default_nettype wire

/* verilog/search_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tuner_params.svh"

module search_sequencer (
  input  var logic                        i_clk,
  input  var logic                        i_rst,
  // Sweep configuration, held stable during a search
  input  var tuner_types_pkg::tune_code_t   i_tune_start,
  input  var tuner_types_pkg::tune_code_t   i_tune_end,
  input  var tuner_types_pkg::tune_stride_t i_tune_stride,
  // Trigger handshake
  input  var logic                        i_trig,
  output logic                            o_trig_rdy,
  // Measurement transaction
  output logic                            o_txn_val,
  output tuner_types_pkg::tune_code_t     o_txn_code,
  input  var logic                        i_txn_rdy,
  input  var tuner_types_pkg::pwr_t       i_txn_power,
  // Results level
  output logic                            o_peaks_val,
  // Sample stream to detector and recorder
  tuner_sample_if.seq                     smp
);
  import search_state_pkg::*;
  import tuner_types_pkg::*;

  // --------------------
  // Signals
  // --------------------
  search_state_e state;
  search_state_e state_next;

  logic       trig_fire;
  logic       txn_fire;
  logic       last_sample;

  tune_code_t tune_code;
  tune_code_t tune_step;
  // Fires taken so far in this sweep
  tune_code_t sample_cnt;
  // Index of the final sample, N
  tune_code_t sample_last;

  // --------------------
  // Handshakes
  // --------------------
  assign o_trig_rdy  = (state == S_IDLE) || (state == S_DONE);
  assign o_peaks_val = (state == S_DONE);
  assign o_txn_val   = (state == S_ACTIVE);
  assign o_txn_code  = tune_code;

  assign trig_fire = i_trig && o_trig_rdy;
  assign txn_fire  = o_txn_val && i_txn_rdy;

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:   if (trig_fire) state_next = S_INIT;
      // Single cycle clear of the datapath
      S_INIT:   state_next = S_ACTIVE;
      // Leave right after the last fire
      S_ACTIVE: if (txn_fire && last_sample) state_next = S_DONE;
      // Retrigger allowed, results held until then
      S_DONE:   if (trig_fire) state_next = S_INIT;
      default:  state_next = S_IDLE;
    endcase
  end

  // --------------------
  // Code sweep
  // --------------------
  assign tune_step   = tune_code_t'(1) << i_tune_stride;
  // N = (end - start) >> stride, so N+1 samples
  assign sample_last = (i_tune_end - i_tune_start) >> i_tune_stride;
  assign last_sample = (sample_cnt == sample_last);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      tune_code  <= '0;
      sample_cnt <= '0;
    end else if (state == S_INIT) begin
      tune_code  <= i_tune_start;
      sample_cnt <= '0;
    end else if (txn_fire) begin
      // New code visible the cycle after the fire
      tune_code  <= tune_code + tune_step;
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // Each fire becomes one sample, power taken in the fire cycle
  assign smp.refresh = (state == S_INIT);
  assign smp.update  = txn_fire;
  assign smp.code    = tune_code;
  assign smp.power   = i_txn_power;

endmodule

`default_nettype wire

/* verilog/peak_detector.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tuner_params.svh"

module peak_detector (
  input  var logic                    i_clk,
  input  var logic                    i_rst,
  // Sample stream from the sequencer
  tuner_sample_if.det                 smp,
  // Peak commit towards the recorder
  output logic                        o_commit,
  output tuner_types_pkg::tune_code_t o_commit_code,
  output tuner_types_pkg::pwr_t       o_commit_power
);
  import tuner_types_pkg::*;

  // --------------------
  // Window geometry
  // --------------------
  localparam int half_win = `TUNER_PEAK_HALF_WIN;
  // Flag history behind the sample on the interface
  localparam int win_len  = 2 * half_win - 1;
  // First evaluated update index is 2H
  localparam int warm_len = 2 * half_win;
  localparam int warm_w   = $clog2(warm_len + 1);
  localparam int vote_w   = $clog2(half_win + 1);
  localparam int hold_w   = $clog2(`TUNER_PEAK_HOLDOFF + 1);

  localparam logic [warm_w-1:0] warm_full    = warm_w'(warm_len);
  localparam logic [vote_w-1:0] vote_thres   = vote_w'(`TUNER_PEAK_THRES);
  localparam logic [hold_w-1:0] holdoff_load = hold_w'(`TUNER_PEAK_HOLDOFF);

  // --------------------
  // Signals
  // --------------------
  // Index 0 holds the previous sample u-1
  tune_code_t win_code [half_win];
  pwr_t       win_pwr  [half_win];
  logic [win_len-1:0] win_rise;
  logic [win_len-1:0] win_fall;

  pwr_t prev_power;
  logic rise_new;
  logic fall_new;

  logic [half_win-1:0] rise_vec;
  logic [half_win-1:0] fall_vec;
  logic [vote_w-1:0]   rise_votes;
  logic [vote_w-1:0]   fall_votes;

  logic [warm_w-1:0] warm_cnt;
  logic [hold_w-1:0] holdoff_cnt;
  logic              evaluate;
  logic              peak_found;

  // Counts set flags in one half window
  function automatic logic [vote_w-1:0] count_votes(input logic [half_win-1:0] flags);
    logic [vote_w-1:0] sum;
    sum = '0;
    for (int i = 0; i < half_win; i++) begin
      sum = sum + vote_w'(flags[i]);
    end
    return sum;
  endfunction

  // --------------------
  // Step flags
  // --------------------
  // Cleared window makes sample 0 compare against zero
  assign prev_power = win_pwr[0];
  assign rise_new   = smp.power > prev_power;
  assign fall_new   = smp.power < prev_power;

  // Flags shift in at index 0
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      win_rise <= '0;
      win_fall <= '0;
    end else if (smp.refresh) begin
      win_rise <= '0;
      win_fall <= '0;
    end else if (smp.update) begin
      win_rise <= {win_rise[win_len-2:0], rise_new};
      win_fall <= {win_fall[win_len-2:0], fall_new};
    end
  end

  // Code and power kept from u-1 back to the candidate
  always_ff @(posedge i_clk) begin
    if (smp.refresh) begin
      win_code <= '{default: '0};
      win_pwr  <= '{default: '0};
    end else if (smp.update) begin
      win_code[0] <= smp.code;
      win_pwr[0]  <= smp.power;
      for (int i = 1; i < half_win; i++) begin
        win_code[i] <= win_code[i-1];
        win_pwr[i]  <= win_pwr[i-1];
      end
    end
  end

  // --------------------
  // Votes
  // --------------------
  // Candidate m = u-H sits at index H-1
  // Rises of m-H+1..m and falls of m+1..u where u is still on the interface
  assign rise_vec   = win_rise[win_len-1:half_win-1];
  assign fall_vec   = {win_fall[half_win-2:0], fall_new};
  assign rise_votes = count_votes(rise_vec);
  assign fall_votes = count_votes(fall_vec);
  assign peak_found = (rise_votes >= vote_thres) && (fall_votes >= vote_thres);

  // Full window needed before any candidate counts
  assign evaluate = smp.update && (warm_cnt == warm_full);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      warm_cnt <= '0;
    end else if (smp.refresh) begin
      warm_cnt <= '0;
    end else if (smp.update && (warm_cnt != warm_full)) begin
      warm_cnt <= warm_cnt + 1'b1;
    end
  end

  // --------------------
  // Hold-off
  // --------------------
  // Suppresses the next HOLDOFF candidates after a commit
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      holdoff_cnt <= '0;
    end else if (smp.refresh) begin
      holdoff_cnt <= '0;
    end else if (o_commit) begin
      holdoff_cnt <= holdoff_load;
    end else if (evaluate && (holdoff_cnt != '0)) begin
      holdoff_cnt <= holdoff_cnt - 1'b1;
    end
  end

  assign o_commit       = evaluate && peak_found && (holdoff_cnt == '0);
  assign o_commit_code  = win_code[half_win-1];
  assign o_commit_power = win_pwr[half_win-1];

endmodule

`default_nettype wire

/* verilog/peak_recorder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tuner_params.svh"

module peak_recorder (
  input  var logic                        i_clk,
  input  var logic                        i_rst,
  // Clear pulse at search start
  tuner_sample_if.rec                     smp,
  // Commit from the detector
  input  var logic                        i_commit,
  input  var tuner_types_pkg::tune_code_t i_commit_code,
  input  var tuner_types_pkg::pwr_t       i_commit_power,
  // Stored results
  output tuner_types_pkg::peak_cnt_t      o_peak_cnt,
  output tuner_types_pkg::tune_code_t     o_peak_codes  [`TUNER_NUM_TARGET],
  output tuner_types_pkg::pwr_t           o_peak_powers [`TUNER_NUM_TARGET]
);
  import tuner_types_pkg::*;

  localparam peak_cnt_t cnt_full = peak_cnt_t'(`TUNER_NUM_TARGET);

  tune_code_t peak_codes  [`TUNER_NUM_TARGET];
  pwr_t       peak_powers [`TUNER_NUM_TARGET];
  peak_cnt_t  peak_cnt;
  logic       has_room;

  // Extra commits dropped once all slots are used
  assign has_room = (peak_cnt != cnt_full);

  // Count saturates at NUM_TARGET
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      peak_cnt <= '0;
    end else if (smp.refresh) begin
      peak_cnt <= '0;
    end else if (i_commit && has_room) begin
      peak_cnt <= peak_cnt + 1'b1;
    end
  end

  // Slot written at the current count
  always_ff @(posedge i_clk) begin
    if (smp.refresh) begin
      peak_codes  <= '{default: '0};
      peak_powers <= '{default: '0};
    end else if (i_commit && has_room) begin
      peak_codes[peak_idx_t'(peak_cnt)]  <= i_commit_code;
      peak_powers[peak_idx_t'(peak_cnt)] <= i_commit_power;
    end
  end

  assign o_peak_cnt    = peak_cnt;
  assign o_peak_codes  = peak_codes;
  assign o_peak_powers = peak_powers;

endmodule

`default_nettype wire

/* verilog/tuner_search_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tuner_params.svh"

module tuner_search_top (
  input  var logic                          i_clk,
  input  var logic                          i_rst,
  // Sweep configuration
  input  var tuner_types_pkg::tune_code_t   i_tune_start,
  input  var tuner_types_pkg::tune_code_t   i_tune_end,
  input  var tuner_types_pkg::tune_stride_t i_tune_stride,
  // Trigger handshake
  input  var logic                          i_trig,
  output logic                              o_trig_rdy,
  // Measurement transaction
  output logic                              o_txn_val,
  output tuner_types_pkg::tune_code_t       o_txn_code,
  input  var logic                          i_txn_rdy,
  input  var tuner_types_pkg::pwr_t         i_txn_power,
  // Results, level valid in S_DONE
  output logic                              o_peaks_val,
  output tuner_types_pkg::peak_cnt_t        o_peak_cnt,
  output tuner_types_pkg::tune_code_t       o_peak_codes  [`TUNER_NUM_TARGET],
  output tuner_types_pkg::pwr_t             o_peak_powers [`TUNER_NUM_TARGET]
);
  import tuner_types_pkg::*;

  // Detector to recorder
  logic       commit;
  tune_code_t commit_code;
  pwr_t       commit_power;

  // Shared sample stream
  tuner_sample_if smp ();

  // --------------------
  // Sweep and handshakes
  // --------------------
  search_sequencer u_sequencer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_tune_start  (i_tune_start),
    .i_tune_end    (i_tune_end),
    .i_tune_stride (i_tune_stride),
    .i_trig        (i_trig),
    .o_trig_rdy    (o_trig_rdy),
    .o_txn_val     (o_txn_val),
    .o_txn_code    (o_txn_code),
    .i_txn_rdy     (i_txn_rdy),
    .i_txn_power   (i_txn_power),
    .o_peaks_val   (o_peaks_val),
    .smp           (smp.seq)
  );

  // --------------------
  // Peak search
  // --------------------
  peak_detector u_detector (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .smp            (smp.det),
    .o_commit       (commit),
    .o_commit_code  (commit_code),
    .o_commit_power (commit_power)
  );

  peak_recorder u_recorder (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .smp            (smp.rec),
    .i_commit       (commit),
    .i_commit_code  (commit_code),
    .i_commit_power (commit_power),
    .o_peak_cnt     (o_peak_cnt),
    .o_peak_codes   (o_peak_codes),
    .o_peak_powers  (o_peak_powers)
  );

endmodule

`default_nettype wire

/* testbench/search_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tuner_params.svh"

module search_checker (
  input  var logic                          i_clk,
  input  var logic                          i_rst,
  // DUT ports under watch
  input  var logic                          i_trig,
  input  var logic                          i_trig_rdy,
  input  var logic                          i_txn_val,
  input  var tuner_types_pkg::tune_code_t   i_txn_code,
  input  var logic                          i_txn_rdy,
  input  var logic                          i_peaks_val,
  input  var tuner_types_pkg::peak_cnt_t    i_peak_cnt,
  input  var tuner_types_pkg::tune_code_t   i_peak_codes  [`TUNER_NUM_TARGET],
  input  var tuner_types_pkg::pwr_t         i_peak_powers [`TUNER_NUM_TARGET],
  // Configuration and expected peaks of the next test
  input  var tuner_types_pkg::tune_code_t   i_exp_start,
  input  var tuner_types_pkg::tune_code_t   i_exp_end,
  input  var tuner_types_pkg::tune_stride_t i_exp_stride,
  input  var tuner_types_pkg::peak_cnt_t    i_exp_cnt,
  input  var tuner_types_pkg::tune_code_t   i_exp_codes  [`TUNER_NUM_TARGET],
  input  var tuner_types_pkg::pwr_t         i_exp_powers [`TUNER_NUM_TARGET],
  output int                                o_err_cnt,
  output int                                o_tests_done,
  output int                                o_tests_passed
);
  import search_state_pkg::*;
  import tuner_types_pkg::*;

  localparam int num_target = `TUNER_NUM_TARGET;

  search_state_e exp_state = S_IDLE;
  tune_code_t    start_code;
  tune_code_t    exp_code;
  tune_code_t    diff;
  tune_stride_t  stride;
  peak_cnt_t     exp_cnt;
  tune_code_t    exp_codes  [num_target];
  pwr_t          exp_powers [num_target];
  int            n_last;
  int            n_fires;
  int            err_cnt = 0;
  int            test_errs = 0;
  int            tests_done = 0;
  int            tests_passed = 0;
  logic          after_reset = 1'b0;
  logic          compare_pending = 1'b0;

  assign o_err_cnt      = err_cnt;
  assign o_tests_done   = tests_done;
  assign o_tests_passed = tests_passed;

  task automatic report(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_cnt++;
    test_errs++;
  endtask

  // All slots, so stale peaks from an earlier run show up too
  task automatic compare_results();
    if (i_peak_cnt !== exp_cnt) begin
      report($sformatf("peak count %0d, expected %0d", i_peak_cnt, exp_cnt));
    end
    for (int i = 0; i < num_target; i++) begin
      if (i_peak_codes[i] !== exp_codes[i] || i_peak_powers[i] !== exp_powers[i]) begin
        report($sformatf("slot %0d holds %h/%h, expected %h/%h", i, i_peak_codes[i],
                         i_peak_powers[i], exp_codes[i], exp_powers[i]));
      end
    end
  endtask

  // --------------------
  // Reference FSM
  // --------------------
  // Everything sampled at the falling edge, away from input changes
  always @(negedge i_clk) begin
    if (i_rst) begin
      exp_state   = S_IDLE;
      after_reset = 1'b1;
    end else begin
      if (after_reset && i_peak_cnt !== '0) begin
        report("peak count not zero after reset");
      end
      after_reset = 1'b0;
      if (i_trig_rdy !== (exp_state == S_IDLE || exp_state == S_DONE)) begin
        report($sformatf("trigger ready %b in %s", i_trig_rdy, exp_state.name()));
      end
      if (i_txn_val !== (exp_state == S_ACTIVE)) begin
        report($sformatf("txn valid %b in %s", i_txn_val, exp_state.name()));
      end
      if (i_peaks_val !== (exp_state == S_DONE)) begin
        report($sformatf("peaks valid %b in %s", i_peaks_val, exp_state.name()));
      end
      // Results valid one cycle after the last fire
      if (exp_state == S_DONE && compare_pending) begin
        compare_results();
        compare_pending = 1'b0;
        tests_done++;
        if (test_errs == 0) begin
          tests_passed++;
          $display("test %0d: pass", tests_done);
        end else begin
          $display("test %0d: fail, %0d errors", tests_done, test_errs);
        end
      end else if (exp_state == S_DONE) begin
        compare_results();
      end
      case (exp_state)
        S_IDLE, S_DONE: begin
          if (i_trig && i_trig_rdy) begin
            start_code = i_exp_start;
            stride     = i_exp_stride;
            diff       = i_exp_end - i_exp_start;
            n_last     = int'(diff >> stride);
            exp_cnt    = i_exp_cnt;
            exp_codes  = i_exp_codes;
            exp_powers = i_exp_powers;
            n_fires    = 0;
            test_errs  = 0;
            exp_state  = S_INIT;
          end
        end
        S_INIT: exp_state = S_ACTIVE;
        S_ACTIVE: begin
          if (i_txn_val && i_txn_rdy) begin
            exp_code = start_code + tune_code_t'(n_fires << stride);
            if (i_txn_code !== exp_code) begin
              report($sformatf("fire %0d code %h, expected %h", n_fires, i_txn_code, exp_code));
            end
            n_fires++;
            if (n_fires == n_last + 1) begin
              exp_state       = S_DONE;
              compare_pending = 1'b1;
            end
          end
        end
        default: exp_state = S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_tuner_search.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tuner_params.svh"

module tb_tuner_search;
  import tuner_types_pkg::*;

  localparam time clk_period = 100ns;
  localparam time stim_delay = 10ns;
  localparam int  mem_depth  = 1024;
  localparam int  max_tests  = 8;
  localparam int  num_target = `TUNER_NUM_TARGET;

  // --------------------
  // DUT signals
  // --------------------
  logic         i_clk;
  logic         i_rst;
  tune_code_t   i_tune_start;
  tune_code_t   i_tune_end;
  tune_stride_t i_tune_stride;
  logic         i_trig;
  logic         o_trig_rdy;
  logic         o_txn_val;
  tune_code_t   o_txn_code;
  logic         i_txn_rdy;
  pwr_t         i_txn_power;
  logic         o_peaks_val;
  peak_cnt_t    o_peak_cnt;
  tune_code_t   o_peak_codes  [num_target];
  pwr_t         o_peak_powers [num_target];

  // Expected results handed to the checker
  peak_cnt_t    exp_cnt;
  tune_code_t   exp_codes  [num_target];
  pwr_t         exp_powers [num_target];
  int           err_cnt;
  int           tests_done;
  int           tests_passed;

  // Trace contents and per-test offsets
  logic [7:0]   trace_mem [mem_depth];
  int           num_tests;
  int           cfg_base  [max_tests];
  int           pwr_base  [max_tests];
  int           last_idx  [max_tests];
  int           exp_base  [max_tests];
  int           cur_base = 0;
  int           cur_last = 0;
  int           cycle_limit = 0;
  int           cycle_cnt;

  tuner_search_top dut0 (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_tune_start(i_tune_start), .i_tune_end(i_tune_end), .i_tune_stride(i_tune_stride),
    .i_trig(i_trig), .o_trig_rdy(o_trig_rdy),
    .o_txn_val(o_txn_val), .o_txn_code(o_txn_code),
    .i_txn_rdy(i_txn_rdy), .i_txn_power(i_txn_power),
    .o_peaks_val(o_peaks_val), .o_peak_cnt(o_peak_cnt),
    .o_peak_codes(o_peak_codes), .o_peak_powers(o_peak_powers)
  );

  search_checker u_checker (
    .i_clk(i_clk), .i_rst(i_rst), .i_trig(i_trig), .i_trig_rdy(o_trig_rdy),
    .i_txn_val(o_txn_val), .i_txn_code(o_txn_code), .i_txn_rdy(i_txn_rdy),
    .i_peaks_val(o_peaks_val), .i_peak_cnt(o_peak_cnt),
    .i_peak_codes(o_peak_codes), .i_peak_powers(o_peak_powers),
    .i_exp_start(i_tune_start), .i_exp_end(i_tune_end), .i_exp_stride(i_tune_stride),
    .i_exp_cnt(exp_cnt), .i_exp_codes(exp_codes), .i_exp_powers(exp_powers),
    .o_err_cnt(err_cnt), .o_tests_done(tests_done), .o_tests_passed(tests_passed)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    i_clk = 1'b0;
    forever #(clk_period / 2) i_clk = ~i_clk;
  end

  // --------------------
  // Trace parsing
  // --------------------
  task automatic parse_trace();
    int         p;
    int         total;
    tune_code_t diff;
    $readmemh("testbench/search_trace.txt", trace_mem);
    num_tests = int'(trace_mem[0]);
    p = 1;
    total = 0;
    for (int t = 0; t < num_tests; t++) begin
      cfg_base[t] = p;
      diff        = trace_mem[p+1] - trace_mem[p];
      last_idx[t] = int'(diff >> trace_mem[p+2][2:0]);
      pwr_base[t] = p + 3;
      exp_base[t] = p + 3 + last_idx[t] + 1;
      p           = exp_base[t] + 1 + 2 * int'(trace_mem[exp_base[t]]);
      total       = total + last_idx[t] + 1;
    end
    cycle_limit = 2 * total * 4 + 50;
  endtask

  // Loads config and expectations, triggers, waits for the checker
  task automatic run_test(input int t);
    int eb;
    int cnt;
    eb  = exp_base[t];
    cnt = int'(trace_mem[eb]);
    @(posedge i_clk);
    #(stim_delay);
    while (!o_trig_rdy) begin
      @(posedge i_clk);
      #(stim_delay);
    end
    i_tune_start  = trace_mem[cfg_base[t]];
    i_tune_end    = trace_mem[cfg_base[t]+1];
    i_tune_stride = trace_mem[cfg_base[t]+2][2:0];
    cur_base      = pwr_base[t];
    cur_last      = last_idx[t];
    exp_cnt       = peak_cnt_t'(cnt);
    for (int i = 0; i < num_target; i++) begin
      exp_codes[i]  = (i < cnt) ? trace_mem[eb+1+2*i] : '0;
      exp_powers[i] = (i < cnt) ? trace_mem[eb+2+2*i] : '0;
    end
    i_trig = 1'b1;
    @(posedge i_clk);
    #(stim_delay);
    i_trig = 1'b0;
    while (tests_done < t + 1) begin
      @(posedge i_clk);
    end
    // Dwell in S_DONE so the checker sees results held
    repeat (3) @(posedge i_clk);
  endtask

  // --------------------
  // Transaction responder
  // --------------------
  initial begin
    logic        fired;
    logic        trig_seen;
    logic [31:0] lfsr;
    int          fires;
    lfsr        = 32'hd28b;
    fires       = 0;
    i_txn_rdy   = 1'b0;
    i_txn_power = '0;
    forever begin
      @(negedge i_clk);
      fired     = o_txn_val && i_txn_rdy;
      trig_seen = i_trig && o_trig_rdy;
      @(posedge i_clk);
      #(stim_delay);
      if (trig_seen) begin
        fires = 0;
      end else if (fired) begin
        fires++;
      end
      lfsr        = lfsr_step(lfsr);
      i_txn_rdy   = lfsr[0];
      i_txn_power = (fires <= cur_last) ? trace_mem[cur_base+fires] : '0;
    end
  end

  // Hang guard
  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    $display("timeout: no result within %0d cycles, the search seems stuck", cycle_limit);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    i_rst         = 1'b1;
    i_trig        = 1'b0;
    i_tune_start  = '0;
    i_tune_end    = '0;
    i_tune_stride = '0;
    exp_cnt       = '0;
    exp_codes     = '{default: '0};
    exp_powers    = '{default: '0};
    parse_trace();
    repeat (3) @(posedge i_clk);
    #(stim_delay);
    i_rst = 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    repeat (2) @(posedge i_clk);
    $display("tests %0d, passed %0d, errors %0d", tests_done, tests_passed, err_cnt);
    if (err_cnt == 0 && tests_done == num_tests) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/tuner_types_pkg.sv
verilog/search_state_pkg.sv
verilog/tuner_sample_if.sv
verilog/search_sequencer.sv
verilog/peak_detector.sv
verilog/peak_recorder.sv
verilog/tuner_search_top.sv
testbench/search_checker.sv
testbench/tb_tuner_search.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_tuner_search
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/search_trace.txt */
// Word 0 is the test count. Per test: start end stride, then one power per sample,
// then expected peak count and (code power) pairs, all hex
06
// Single clean hump, top at sample 7
20 2f 00  0a 0a 0a 0a 0a 0a 1e 32 1e 0a 0a 0a 0a 0a 0a 0a  01 27 32
// Flat profile with stride 3
00 78 03  40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40  00
// Two humps six apart, second one held off
10 36 01  0a 0a 0a 0a 0a 1e 32 1e 0a 0a 0a 1e 32 1e 0a 0a 0a 0a 0a 0a  01 1c 32
// Two humps ten apart, both kept
00 5c 02  0a 0a 0a 0a 0a 1e 32 1e 0a 0a 0a 0a 0a 0a 0a 1e 40 1e 0a 0a 0a 0a 0a 0a  02 18 32 40 40
// Nine humps nine apart, count saturates at eight
00 51 00
0a 0a 0a 0a 1e 30 1e 0a 0a  0a 0a 0a 0a 1e 31 1e 0a 0a  0a 0a 0a 0a 1e 32 1e 0a 0a
0a 0a 0a 0a 1e 33 1e 0a 0a  0a 0a 0a 0a 1e 34 1e 0a 0a  0a 0a 0a 0a 1e 35 1e 0a 0a
0a 0a 0a 0a 1e 36 1e 0a 0a  0a 0a 0a 0a 1e 37 1e 0a 0a  0a 0a 0a 0a 1e 38 1e 0a 0a
0a
08 05 30 0e 31 17 32 20 33 29 34 32 35 3b 36 44 37
// Retrigger with the single hump again
20 2f 00  0a 0a 0a 0a 0a 0a 1e 32 1e 0a 0a 0a 0a 0a 0a 0a  01 27 32
